// File: Bender.yml
package:
  name: fmac

sources:
  - files:
      - design/fmac_pkg.sv
      - design/fmac_operand_decode.sv
      - design/fmac_product_align.sv
      - design/fmac_normalize_round.sv
      - design/fmac_req_ctrl.sv
      - design/fmac_top.sv
  - target: test
    files:
      - testbench/fmac_assertions.sv
      - testbench/fmac_tb.sv

// File: design/fmac_normalize_round.sv
`timescale 1ns/1ns

module fmac_normalize_round (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               en,
   input  fmac_pkg::aligned_t aln,
   output fmac_pkg::fp_word_t result
);

   // Sum operands with a carry bit, a sign bit and a sticky LSB
   logic [fmac_pkg::acc_w+2:0]   op_prod;
   logic [fmac_pkg::acc_w+2:0]   op_add;
   logic [fmac_pkg::acc_w+2:0]   sum_ext;

   // Magnitude and normalized magnitude
   logic                         neg;
   logic [fmac_pkg::acc_w+1:0]   mag;
   logic [fmac_pkg::shift_w-1:0] lzc;
   logic [fmac_pkg::acc_w+1:0]   norm;

   // Rounding
   fmac_pkg::sig_t               sig_keep;
   logic                         guard;
   logic                         rnd_bit;
   logic                         sticky;
   logic                         round_up;
   logic [fmac_pkg::sig_w:0]     sig_rnd;

   // Packing
   logic                         sign_res;
   fmac_pkg::exp_wide_t          exp_res;
   fmac_pkg::fp_word_t           result_d;

   // Leading-zero count over the whole magnitude
   function automatic logic [fmac_pkg::shift_w-1:0] lead_zeros(
      input logic [fmac_pkg::acc_w+1:0] v
   );
      logic [fmac_pkg::shift_w-1:0] cnt;
      logic                         found;

      cnt   = fmac_pkg::shift_w'(fmac_pkg::acc_w + 2);
      found = 1'b0;
      for (int i = fmac_pkg::acc_w + 1; i >= 0; i--) begin
         if (!found && v[i]) begin
            cnt   = fmac_pkg::shift_w'(fmac_pkg::acc_w + 1 - i);
            found = 1'b1;
         end
      end
      return cnt;
   endfunction

   ////////////////////
   // Add or subtract
   ////////////////////

   // Sticky rides as an extra LSB so a borrow past it comes out right
   assign op_prod = {2'b00, aln.prod, 1'b0};
   assign op_add  = {2'b00, aln.addend, aln.sticky};
   assign sum_ext = aln.eff_sub ? op_prod - op_add : op_prod + op_add;

   // Negative difference flips the result sign
   assign neg      = aln.eff_sub & sum_ext[fmac_pkg::acc_w+2];
   assign mag      = neg ? ~sum_ext[fmac_pkg::acc_w+1:0] + 1'b1 : sum_ext[fmac_pkg::acc_w+1:0];
   assign sign_res = neg ? ~aln.sign_p : aln.sign_p;

   ////////////////////
   // Normalize
   ////////////////////

   assign lzc  = lead_zeros(mag);
   // Leading one moved to the top bit
   assign norm = mag << lzc;

   assign sig_keep = norm[fmac_pkg::acc_w+1 -: fmac_pkg::sig_w];
   assign guard    = norm[fmac_pkg::acc_w+1-fmac_pkg::sig_w];
   assign rnd_bit  = norm[fmac_pkg::acc_w-fmac_pkg::sig_w];
   assign sticky   = |norm[fmac_pkg::acc_w-fmac_pkg::sig_w-1:0];

   ////////////////////
   // Round and pack
   ////////////////////

   // Nearest even, ties go to an even LSB
   assign round_up = guard & (rnd_bit | sticky | sig_keep[0]);
   assign sig_rnd  = {1'b0, sig_keep} + round_up;

   // Carry out of rounding bumps the exponent, fraction is then zero
   assign exp_res = aln.exp_base + fmac_pkg::exp_wide_t'(fmac_pkg::lead_ofs)
                    - fmac_pkg::exp_wide_t'(lzc)
                    + fmac_pkg::exp_wide_t'(sig_rnd[fmac_pkg::sig_w]);

   always_comb begin
      if (aln.special) begin
         result_d = aln.special_word;
      end else if (mag == '0) begin
         // Exact cancellation
         result_d = '0;
      end else if (exp_res >= fmac_pkg::exp_wide_t'(fmac_pkg::exp_inf)) begin
         // Overflow to signed infinity
         result_d = {sign_res, fmac_pkg::exp_t'(fmac_pkg::exp_inf), {fmac_pkg::mant_w{1'b0}}};
      end else if (exp_res < fmac_pkg::exp_wide_t'(fmac_pkg::exp_one)) begin
         // Below normal range flushes to signed zero
         result_d = {sign_res, {(fmac_pkg::word_w-1){1'b0}}};
      end else begin
         result_d = {sign_res, exp_res[fmac_pkg::exp_w-1:0], sig_rnd[fmac_pkg::mant_w-1:0]};
      end
   end

   // Result register, held until the next operation
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else if (en) begin
         result <= result_d;
      end
   end

endmodule

// File: design/fmac_operand_decode.sv
`timescale 1ns/1ns

module fmac_operand_decode (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               en,
   input  fmac_pkg::fp_word_t op_a,
   input  fmac_pkg::fp_word_t op_b,
   input  fmac_pkg::fp_word_t op_c,
   output fmac_pkg::decoded_t dec
);

   // Next value of the stage register
   fmac_pkg::decoded_t dec_d;

   ////////////////////
   // Field split
   ////////////////////

   // Splits one word and flags its class
   function automatic fmac_pkg::fp_unpacked_t unpack(input fmac_pkg::fp_word_t w);
      fmac_pkg::fp_unpacked_t    u;
      fmac_pkg::exp_t            exp_raw;
      logic [fmac_pkg::mant_w-1:0] frac;
      logic                      hidden;
      logic                      frac_zero;
      logic                      exp_max;

      exp_raw   = w[fmac_pkg::mant_w +: fmac_pkg::exp_w];
      frac      = w[fmac_pkg::mant_w-1:0];
      // Hidden bit set for any nonzero exponent
      hidden    = |exp_raw;
      frac_zero = (frac == '0);
      exp_max   = (exp_raw == fmac_pkg::exp_t'(fmac_pkg::exp_inf));

      u.sign     = w[fmac_pkg::word_w-1];
      // Zero and denormal share the all-zero exponent
      u.cls.zero = !hidden && frac_zero;
      u.cls.den  = !hidden && !frac_zero;
      // Inf and NaN share the all-ones exponent
      u.cls.inf  = exp_max && frac_zero;
      u.cls.nan  = exp_max && !frac_zero;

      // Denormal scale matches the smallest normal exponent
      u.exp = u.cls.den ? fmac_pkg::exp_t'(fmac_pkg::exp_one) : exp_raw;
      u.sig = {hidden, frac};
      return u;
   endfunction

   // Same split for all three operands
   always_comb begin
      dec_d.a = unpack(op_a);
      dec_d.b = unpack(op_b);
      dec_d.c = unpack(op_c);
   end

   ////////////////////
   // Stage register
   ////////////////////

   // Captures on the decode enable pulse only
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec <= '0;
      end else if (en) begin
         dec <= dec_d;
      end
   end

endmodule

// File: design/fmac_pkg.sv
package fmac_pkg;

   ////////////////////
   // Binary32 format
   ////////////////////

   // Packed word and its fields
   localparam int word_w = 32;
   localparam int exp_w = 8;
   localparam int mant_w = 23;

   // Significand with hidden bit, and the full product
   localparam int sig_w = mant_w + 1;
   localparam int prod_w = 2 * sig_w;

   // Signed working exponent, wide enough to see overflow and underflow
   localparam int exp_wide_w = 10;

   // Exponent constants
   localparam int exp_bias = 127;
   localparam int exp_inf = 255;
   localparam int exp_one = 1;

   ////////////////////
   // Add window
   ////////////////////

   // Product sits two bits above the window floor
   localparam int prod_lsb = 2;
   // Addend headroom, product, two bits below the product
   localparam int acc_w = prod_w + sig_w + 2 * prod_lsb;
   // Largest exponent lead of the addend that still fits at the window top
   localparam int align_top = acc_w - sig_w - prod_lsb - mant_w;
   // Distance from the top of the sum to the product integer bit
   localparam int lead_ofs = acc_w - prod_lsb - 2 * mant_w;
   // Shift amounts and leading-zero counts
   localparam int shift_w = $clog2(acc_w + 1);

   // Stage registers between request and result
   localparam int pipe_depth = 3;

   ////////////////////
   // Types
   ////////////////////

   typedef logic [word_w-1:0]            fp_word_t;
   typedef logic [exp_w-1:0]             exp_t;
   typedef logic [sig_w-1:0]             sig_t;
   typedef logic [prod_w-1:0]            prod_t;
   typedef logic signed [exp_wide_w-1:0] exp_wide_t;
   typedef logic [acc_w-1:0]             acc_t;

   // Quiet NaN returned for every invalid case
   localparam fp_word_t qnan = 32'h7fc0_0000;

   // Operand classification flags
   typedef struct packed {
      logic zero;
      logic inf;
      logic nan;
      logic den;
   } op_class_t;

   // One operand split into its fields
   typedef struct packed {
      logic      sign;
      exp_t      exp;
      sig_t      sig;
      op_class_t cls;
   } fp_unpacked_t;

   // Decode stage register
   typedef struct packed {
      fp_unpacked_t a;
      fp_unpacked_t b;
      fp_unpacked_t c;
   } decoded_t;

   // Execute stage register
   typedef struct packed {
      logic      sign_p;
      logic      eff_sub;
      exp_wide_t exp_base;
      acc_t      prod;
      acc_t      addend;
      logic      sticky;
      logic      special;
      fp_word_t  special_word;
   } aligned_t;

   // Handshake control states
   typedef enum logic [1:0] {
      idle,
      busy,
      hold
   } ctrl_state_t;

endpackage

// File: design/fmac_product_align.sv
`timescale 1ns/1ns

module fmac_product_align (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               en,
   input  fmac_pkg::decoded_t dec,
   output fmac_pkg::aligned_t aln
);

   // Next value of the stage register
   fmac_pkg::aligned_t aln_d;

   // Product path
   logic                  sign_p;
   fmac_pkg::prod_t       product;
   fmac_pkg::exp_wide_t   exp_prod;

   // Addend alignment
   fmac_pkg::exp_wide_t   exp_c;
   fmac_pkg::exp_wide_t   exp_diff;
   fmac_pkg::exp_wide_t   shift_raw;
   logic                  prod_zero;
   logic                  c_dominant;
   logic [fmac_pkg::shift_w-1:0] shift_amt;
   fmac_pkg::acc_t        addend_top;
   logic [2*fmac_pkg::acc_w-1:0] shift_buf;

   // Special operand detection
   logic                  nan_any;
   logic                  prod_inf;
   logic                  inf_times_zero;
   logic                  inf_cancel;

   ////////////////////
   // Product
   ////////////////////

   assign sign_p   = dec.a.sign ^ dec.b.sign;
   assign product  = fmac_pkg::prod_t'(dec.a.sig) * fmac_pkg::prod_t'(dec.b.sig);
   // Biased exponent of the product integer bit
   assign exp_prod = fmac_pkg::exp_wide_t'(dec.a.exp) + fmac_pkg::exp_wide_t'(dec.b.exp)
                     - fmac_pkg::exp_wide_t'(fmac_pkg::exp_bias);

   ////////////////////
   // Addend alignment
   ////////////////////

   assign exp_c     = fmac_pkg::exp_wide_t'(dec.c.exp);
   assign exp_diff  = exp_c - exp_prod;
   assign prod_zero = dec.a.cls.zero | dec.b.cls.zero;

   // Addend pinned at window top when the product is far below or zero
   // (the product then only counts as a nonzero remainder)
   assign c_dominant = prod_zero | (exp_diff > fmac_pkg::exp_wide_t'(fmac_pkg::align_top));

   // Right shift measured from the top position
   assign shift_raw = fmac_pkg::exp_wide_t'(fmac_pkg::align_top) - exp_diff;

   always_comb begin
      if (c_dominant) begin
         shift_amt = '0;
      end else if (shift_raw > fmac_pkg::exp_wide_t'(fmac_pkg::acc_w)) begin
         // Whole addend lands below the window
         shift_amt = fmac_pkg::shift_w'(fmac_pkg::acc_w);
      end else begin
         shift_amt = fmac_pkg::shift_w'(shift_raw);
      end
   end

   assign addend_top = fmac_pkg::acc_t'(dec.c.sig) << (fmac_pkg::acc_w - fmac_pkg::sig_w);
   // Lower half catches the bits shifted out of the window
   assign shift_buf  = {addend_top, fmac_pkg::acc_t'(0)} >> shift_amt;

   ////////////////////
   // Special operands
   ////////////////////

   assign nan_any        = dec.a.cls.nan | dec.b.cls.nan | dec.c.cls.nan;
   assign prod_inf       = dec.a.cls.inf | dec.b.cls.inf;
   assign inf_times_zero = (dec.a.cls.inf & dec.b.cls.zero) | (dec.a.cls.zero & dec.b.cls.inf);
   // Opposite infinities in the sum
   assign inf_cancel     = prod_inf & dec.c.cls.inf & (sign_p ^ dec.c.sign);

   always_comb begin
      aln_d.sign_p   = sign_p;
      aln_d.eff_sub  = sign_p ^ dec.c.sign;
      aln_d.exp_base = c_dominant ?
                       exp_c - fmac_pkg::exp_wide_t'(fmac_pkg::align_top) : exp_prod;
      aln_d.prod     = fmac_pkg::acc_t'(product) << fmac_pkg::prod_lsb;
      aln_d.addend   = shift_buf[2*fmac_pkg::acc_w-1 -: fmac_pkg::acc_w];
      aln_d.sticky   = |shift_buf[fmac_pkg::acc_w-1:0];

      // Invalid cases first, then infinities, then exact zero
      aln_d.special      = 1'b1;
      aln_d.special_word = '0;
      if (nan_any | inf_times_zero | inf_cancel) begin
         aln_d.special_word = fmac_pkg::qnan;
      end else if (prod_inf) begin
         aln_d.special_word = {sign_p, fmac_pkg::exp_t'(fmac_pkg::exp_inf),
                               {fmac_pkg::mant_w{1'b0}}};
      end else if (dec.c.cls.inf) begin
         aln_d.special_word = {dec.c.sign, fmac_pkg::exp_t'(fmac_pkg::exp_inf),
                               {fmac_pkg::mant_w{1'b0}}};
      end else if (prod_zero & dec.c.cls.zero) begin
         // Negative zero only when both terms are negative
         aln_d.special_word = {sign_p & dec.c.sign, {(fmac_pkg::word_w-1){1'b0}}};
      end else begin
         aln_d.special = 1'b0;
      end
   end

   // Execute stage register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         aln <= '0;
      end else if (en) begin
         aln <= aln_d;
      end
   end

endmodule

// File: design/fmac_req_ctrl.sv
`timescale 1ns/1ns

module fmac_req_ctrl (
   input  logic clk,
   input  logic arst_n,
   input  logic req,
   output logic ack,
   output logic dec_en,
   output logic exe_en,
   output logic res_en
);

   // Control state and stage counter
   fmac_pkg::ctrl_state_t state;
   fmac_pkg::ctrl_state_t state_nxt;
   logic [1:0]            stage_cnt;
   logic [1:0]            stage_cnt_nxt;

   // Registered outputs, next values
   logic                  ack_nxt;
   logic                  dec_en_nxt;
   logic                  exe_en_nxt;
   logic                  res_en_nxt;

   ////////////////////
   // Next state
   ////////////////////

   always_comb begin
      state_nxt     = state;
      stage_cnt_nxt = stage_cnt;
      ack_nxt       = ack;
      // Enables are single-cycle pulses
      dec_en_nxt    = 1'b0;
      exe_en_nxt    = 1'b0;
      res_en_nxt    = 1'b0;

      case (state)
         fmac_pkg::idle: begin
            // Request accepted, decode fires next cycle
            if (req) begin
               state_nxt     = fmac_pkg::busy;
               stage_cnt_nxt = '0;
               dec_en_nxt    = 1'b1;
            end
         end
         fmac_pkg::busy: begin
            if (stage_cnt == 2'(fmac_pkg::pipe_depth - 1)) begin
               // Result register loaded on this edge
               state_nxt = fmac_pkg::hold;
               ack_nxt   = 1'b1;
            end else begin
               stage_cnt_nxt = stage_cnt + 2'd1;
               exe_en_nxt    = (stage_cnt == 2'd0);
               res_en_nxt    = (stage_cnt == 2'd1);
            end
         end
         fmac_pkg::hold: begin
            // Ack held until the requester lets go
            if (!req) begin
               state_nxt = fmac_pkg::idle;
               ack_nxt   = 1'b0;
            end
         end
         default: begin
            state_nxt = fmac_pkg::idle;
         end
      endcase
   end

   ////////////////////
   // State registers
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= fmac_pkg::idle;
         stage_cnt <= '0;
         ack       <= 1'b0;
         dec_en    <= 1'b0;
         exe_en    <= 1'b0;
         res_en    <= 1'b0;
      end else begin
         state     <= state_nxt;
         stage_cnt <= stage_cnt_nxt;
         ack       <= ack_nxt;
         dec_en    <= dec_en_nxt;
         exe_en    <= exe_en_nxt;
         res_en    <= res_en_nxt;
      end
   end

endmodule

// File: design/fmac_top.sv
`timescale 1ns/1ns

module fmac_top (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               req,
   input  fmac_pkg::fp_word_t op_a,
   input  fmac_pkg::fp_word_t op_b,
   input  fmac_pkg::fp_word_t op_c,
   output logic               ack,
   output fmac_pkg::fp_word_t result
);

   // Stage enables from the handshake control
   logic               dec_en;
   logic               exe_en;
   logic               res_en;

   // Stage registers
   fmac_pkg::decoded_t dec;
   fmac_pkg::aligned_t aln;

   // Four-phase handshake and stage sequencing
   fmac_req_ctrl u_fmac_req_ctrl (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .ack    (ack),
      .dec_en (dec_en),
      .exe_en (exe_en),
      .res_en (res_en)
   );

   // Decode stage
   fmac_operand_decode u_fmac_operand_decode (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (dec_en),
      .op_a   (op_a),
      .op_b   (op_b),
      .op_c   (op_c),
      .dec    (dec)
   );

   // Execute stage
   fmac_product_align u_fmac_product_align (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (exe_en),
      .dec    (dec),
      .aln    (aln)
   );

   // Result stage
   fmac_normalize_round u_fmac_normalize_round (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (res_en),
      .aln    (aln),
      .result (result)
   );

endmodule

// File: src.f
design/fmac_pkg.sv
design/fmac_operand_decode.sv
design/fmac_product_align.sv
design/fmac_normalize_round.sv
design/fmac_req_ctrl.sv
design/fmac_top.sv
testbench/fmac_assertions.sv
testbench/fmac_tb.sv

// File: testbench/fmac_assertions.sv
`timescale 1ns/1ns

module fmac_assertions (
   input logic               clk,
   input logic               arst_n,
   input logic               req,
   input logic               ack,
   input fmac_pkg::fp_word_t result
);

   // Stage edges between request sampling and ack
   localparam int ack_delay = 3;

   // Number of failed assertions
   int fail_count = 0;

   ////////////////////
   // Handshake timing
   ////////////////////

   // Ack registered on the third edge shows from the fourth sample
   ack_latency_a : assert property (
      @(posedge clk) disable iff (!arst_n)
      $rose(req) |=> !ack [*ack_delay] ##1 ack
   ) else begin
      $error("ack did not rise exactly %0d cycles after req", ack_delay);
      fail_count++;
   end

   // Hold state leaves on the first low req
   ack_release_a : assert property (
      @(posedge clk) disable iff (!arst_n)
      (ack && !req) |=> !ack
   ) else begin
      $error("ack did not fall one cycle after req fell");
      fail_count++;
   end

   // Result register frozen while ack stays high
   result_stable_a : assert property (
      @(posedge clk) disable iff (!arst_n)
      (ack ##1 ack) |-> $stable(result)
   ) else begin
      $error("result changed while ack was high");
      fail_count++;
   end

   ////////////////////
   // Reset
   ////////////////////

   ack_in_reset_a : assert property (
      @(posedge clk) !arst_n |-> !ack
   ) else begin
      $error("ack high during reset");
      fail_count++;
   end

   ack_after_reset_a : assert property (
      @(posedge clk) $rose(arst_n) |-> !ack
   ) else begin
      $error("ack high right after reset");
      fail_count++;
   end

endmodule

// File: testbench/fmac_tb.sv
`timescale 1ns/1ns

module fmac_tb;

   // Clock and handshake timing
   localparam int clk_period   = 8;
   localparam int reset_cycles = 4;
   localparam int ack_latency  = 3;
   localparam int hold_cycles  = 5;

   // One table row of operands and the hand-computed binary32 result
   typedef struct packed {
      fmac_pkg::fp_word_t a;
      fmac_pkg::fp_word_t b;
      fmac_pkg::fp_word_t c;
      fmac_pkg::fp_word_t exp_word;
      logic               hold;
   } vector_t;

   logic               clk;
   logic               arst_n;
   logic               req;
   fmac_pkg::fp_word_t op_a;
   fmac_pkg::fp_word_t op_b;
   fmac_pkg::fp_word_t op_c;
   logic               ack;
   fmac_pkg::fp_word_t result;

   // Vector table and bookkeeping
   vector_t vectors[$];
   string   names[$];
   int      err_cnt;
   int      pass_cnt;
   int      fail_cnt;
   int      cycle_cnt;
   int      timeout_limit;

   ////////////////////
   // Clock and DUT
   ////////////////////

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   fmac_top u_fmac_top (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .op_a   (op_a),
      .op_b   (op_b),
      .op_c   (op_c),
      .ack    (ack),
      .result (result)
   );

   // Handshake checks ride along inside the DUT
   bind fmac_top fmac_assertions u_fmac_assertions (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .ack    (ack),
      .result (result)
   );

   // Procedural errors plus failed bound assertions
   function automatic int error_total();
      return err_cnt + u_fmac_top.u_fmac_assertions.fail_count;
   endfunction

   // Run limit of ten cycles per vector plus reset margin
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= timeout_limit) begin
         $display("Timeout: run stopped after %0d cycles without finishing", cycle_cnt);
         $display("Some tests failed");
         $finish;
      end
   end

   ////////////////////
   // Table
   ////////////////////

   task automatic add_vector(input string name, input fmac_pkg::fp_word_t a,
                             input fmac_pkg::fp_word_t b, input fmac_pkg::fp_word_t c,
                             input fmac_pkg::fp_word_t exp_word, input logic hold);
      vector_t v;
      v.a        = a;
      v.b        = b;
      v.c        = c;
      v.exp_word = exp_word;
      v.hold     = hold;
      vectors.push_back(v);
      names.push_back(name);
   endtask

   task automatic build_table();
      // Exact sums with back-pressure on the first one
      add_vector("two_times_three_plus_one", 32'h40000000, 32'h40400000, 32'h3f800000,
                 32'h40e00000, 1'b1);
      add_vector("one_half_times_two_minus_four", 32'h3fc00000, 32'h40000000, 32'hc0800000,
                 32'hbf800000, 1'b0);
      add_vector("halves_plus_quarter", 32'h3f000000, 32'h3f000000, 32'h3e800000,
                 32'h3f000000, 1'b0);
      // (1+2^-23)(1-2^-23) - 1 = -2^-46 only with one rounding
      add_vector("single_rounding", 32'h3f800001, 32'h3f7ffffe, 32'hbf800000,
                 32'ha8800000, 1'b0);
      // 1 + 2^-24 is a tie that rounds to the even 1.0
      add_vector("tie_to_even", 32'h3f800000, 32'h3f800000, 32'h33800000,
                 32'h3f800000, 1'b0);
      // Special operands
      add_vector("nan_operand", 32'h7f800123, 32'h3f800000, 32'h3f800000,
                 32'h7fc00000, 1'b0);
      add_vector("inf_times_zero", 32'h7f800000, 32'h00000000, 32'h3f800000,
                 32'h7fc00000, 1'b0);
      add_vector("inf_minus_inf", 32'h7f800000, 32'h3f800000, 32'hff800000,
                 32'h7fc00000, 1'b0);
      add_vector("inf_times_two_plus_one", 32'h7f800000, 32'h40000000, 32'h3f800000,
                 32'h7f800000, 1'b0);
      add_vector("zero_product_neg_zero", 32'h00000000, 32'hbf800000, 32'h80000000,
                 32'h80000000, 1'b0);
      add_vector("exact_cancel", 32'h40000000, 32'h40400000, 32'hc0c00000,
                 32'h00000000, 1'b0);
      // Range limits
      add_vector("overflow_to_inf", 32'h7f7fffff, 32'h40000000, 32'h00000000,
                 32'h7f800000, 1'b0);
      // 2^-127 denormal times 2^24 is 2^-103
      add_vector("denormal_operand", 32'h00400000, 32'h4b800000, 32'h00000000,
                 32'h0c000000, 1'b0);
      // 2^-150 lies below the normal range
      add_vector("underflow_flush", 32'h0d800000, 32'h26800000, 32'h00000000,
                 32'h00000000, 1'b0);
   endtask

   ////////////////////
   // One handshake
   ////////////////////

   task automatic run_handshake(input int idx);
      vector_t v;
      string   name;
      int      errs_before;
      int      waited;

      v           = vectors[idx];
      name        = names[idx];
      errs_before = error_total();
      waited      = 0;

      // Operands and req together on the falling edge
      @(negedge clk);
      op_a = v.a;
      op_b = v.b;
      op_c = v.c;
      req  = 1'b1;
      while (!ack) begin
         @(negedge clk);
         waited++;
      end
      // One falling edge for the sampling edge and three for the stage edges
      if (waited != ack_latency + 1) begin
         $display("CHECK FAILED %s: ack latency expected %0d, actual %0d", name,
                  ack_latency + 1, waited);
         err_cnt++;
      end
      if (result !== v.exp_word) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, v.exp_word, result);
         err_cnt++;
      end

      // Under back-pressure ack and result must not move
      if (v.hold) begin
         repeat (hold_cycles) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
               $display("CHECK FAILED %s: ack while req high expected 1, actual %b", name,
                        ack);
               err_cnt++;
            end
            if (result !== v.exp_word) begin
               $display("CHECK FAILED %s: expected %h, actual %h", name, v.exp_word, result);
               err_cnt++;
            end
         end
      end

      req = 1'b0;
      @(negedge clk);
      if (ack !== 1'b0) begin
         $display("CHECK FAILED %s: ack after req fell expected 0, actual %b", name, ack);
         err_cnt++;
      end
      while (ack) @(negedge clk);

      if (error_total() == errs_before) begin
         pass_cnt++;
         $display("test %0d %s: ok", idx, name);
      end else begin
         fail_cnt++;
         $display("test %0d %s: failed", idx, name);
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      arst_n    = 1'b0;
      req       = 1'b0;
      op_a      = '0;
      op_b      = '0;
      op_c      = '0;
      err_cnt   = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      cycle_cnt = 0;

      build_table();
      timeout_limit = vectors.size() * 10 + 20;

      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      if (ack !== 1'b0) begin
         $display("CHECK FAILED reset: ack expected 0, actual %b", ack);
         err_cnt++;
      end
      if (result !== '0) begin
         $display("CHECK FAILED reset: result expected %h, actual %h", 32'h0, result);
         err_cnt++;
      end

      for (int i = 0; i < vectors.size(); i++) begin
         run_handshake(i);
      end

      $display("tests: %0d, passed: %0d, failed: %0d, errors: %0d", vectors.size(), pass_cnt,
               fail_cnt, error_total());
      if (error_total() == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
